// File: Makefile
VERILATOR ?= verilator
TOP ?= io_subsystem_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_PATTERN ?= TESTBENCH FAILED
PASS_PATTERN ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_PATTERN)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_PATTERN)" $(LOG) || { echo "Simulation ended without passing"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
io_pkg.sv
io_req_if.sv
io_decode.sv
io_leds_register.sv
io_irq_control.sv
io_timer.sv
io_response.sv
io_subsystem.sv
io_subsystem_props.sv
tb_clock_gen.sv
io_subsystem_tb.sv

// File: io_decode.sv
// I/O port address decoder
`timescale 1ns/1ps
`default_nettype none

module io_decode (
    input logic clk,
    input logic reset,
    input logic access,
    input logic [io_pkg::IO_ADDR_W:1] addr,
    input logic wr_en,
    input logic [1:0] bytesel,
    input logic [io_pkg::DATA_W-1:0] wdata,
    input logic ack,
    output logic leds_cs,
    output logic irq_cs,
    output logic timer_cs,
    output logic default_cs,
    io_req_if.decoder req
);
    import io_pkg::*;

    logic [DATA_W-1:0] port_addr;
    logic busy; // Select given, ack not seen yet
    logic any_cs;

    assign port_addr = {addr, 1'b0};
    assign any_cs = leds_cs | irq_cs | timer_cs | default_cs;

    always_comb begin
        leds_cs = 1'b0;
        irq_cs = 1'b0;
        timer_cs = 1'b0;
        default_cs = 1'b0;

        if (access && !busy) begin
            if (port_addr == LEDS_PORT)
                leds_cs = 1'b1;
            else if (port_addr == IRQ_CONTROL_PORT)
                irq_cs = 1'b1;
            else if (port_addr[15:2] == TIMER_PORT[15:2])
                timer_cs = 1'b1;
            else
                default_cs = 1'b1; // Unmapped, acked with zero data
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            busy <= 1'b0;
        else if (ack)
            busy <= 1'b0;
        else if (any_cs)
            busy <= 1'b1;
    end

    assign req.wr_en = wr_en;
    assign req.bytesel = bytesel;
    assign req.wdata = wdata;
    assign req.addr_sel = addr[1];

endmodule

`default_nettype wire

// File: io_irq_control.sv
// Interrupt test and control register
`timescale 1ns/1ps
`default_nettype none

module io_irq_control (
    input logic clk,
    input logic reset,
    input logic cs,
    input logic timer_intr,
    io_req_if.target req,
    output logic ack,
    output io_pkg::io_word_t rdata,
    output logic [io_pkg::NUM_IRQS-1:0] irqs,
    output logic nmi
);
    import io_pkg::*;

    logic [6:0] intr_test;
    io_word_t cur;
    io_word_t nxt;
    logic access;

    assign access = cs & ~ack;

    always_comb begin
        cur.word = {nmi, 8'b0, intr_test};
        nxt = cur;
        if (req.bytesel[0])
            nxt.bytes.lo = req.wdata.bytes.lo;
        if (req.bytesel[1])
            nxt.bytes.hi = req.wdata.bytes.hi;
    end

    // Timer on line 0, line 7 unused
    assign irqs = NUM_IRQS'(intr_test) | NUM_IRQS'(timer_intr);

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
            rdata <= '0;
            intr_test <= '0;
            nmi <= 1'b0;
        end else begin
            ack <= access;
            rdata <= '0;
            if (access && req.wr_en) begin
                intr_test <= nxt.word[6:0];
                nmi <= nxt.word[15];
            end
            if (access && !req.wr_en)
                rdata <= cur;
        end
    end

endmodule

`default_nettype wire

// File: io_leds_register.sv
// LED output register
`timescale 1ns/1ps
`default_nettype none

module io_leds_register #(
    parameter int NUM_LEDS = 8
) (
    input logic clk,
    input logic reset,
    input logic cs,
    io_req_if.target req,
    output logic ack,
    output io_pkg::io_word_t rdata,
    output logic [NUM_LEDS-1:0] leds
);
    import io_pkg::*;

    io_word_t cur;
    io_word_t nxt;
    logic access;

    assign access = cs & ~ack;

    always_comb begin
        cur.word = DATA_W'(leds); // Zero extended
        nxt = cur;
        if (req.bytesel[0])
            nxt.bytes.lo = req.wdata.bytes.lo;
        if (req.bytesel[1])
            nxt.bytes.hi = req.wdata.bytes.hi;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
            rdata <= '0;
            leds <= '0;
        end else begin
            ack <= access;
            rdata <= '0;
            if (access && req.wr_en)
                leds <= nxt.word[NUM_LEDS-1:0];
            if (access && !req.wr_en)
                rdata <= cur;
        end
    end

endmodule

`default_nettype wire

// File: io_pkg.sv
// I/O port block definitions
`default_nettype none

package io_pkg;

    localparam int IO_ADDR_W = 15; // Word address, bits 15:1
    localparam int DATA_W = 16;
    localparam int NUM_IRQS = 8;

    // Byte port addresses
    localparam logic [15:0] LEDS_PORT = 16'hfffe;
    localparam logic [15:0] IRQ_CONTROL_PORT = 16'hfff6;
    localparam logic [15:0] TIMER_PORT = 16'h0040; // Two words, 0040 and 0042

    // Bus word, whole or split for byte enables
    typedef union packed {
        logic [DATA_W-1:0] word;
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
    } io_word_t;

endpackage

`default_nettype wire

// File: io_req_if.sv
// I/O write request bundle
`timescale 1ns/1ps
`default_nettype none

interface io_req_if;
    import io_pkg::*;

    logic wr_en;
    logic [1:0] bytesel;
    io_word_t wdata;
    logic addr_sel; // Address bit 1, word within a port

    modport decoder(output wr_en, output bytesel, output wdata, output addr_sel);

    modport target(input wr_en, input bytesel, input wdata, input addr_sel);

endinterface

`default_nettype wire

// File: io_response.sv
// Read data and acknowledge merge
`timescale 1ns/1ps
`default_nettype none

module io_response (
    input logic clk,
    input logic reset,
    input logic default_cs,
    input logic leds_ack,
    input io_pkg::io_word_t leds_rdata,
    input logic irq_ack,
    input io_pkg::io_word_t irq_rdata,
    input logic timer_ack,
    input io_pkg::io_word_t timer_rdata,
    output logic ack,
    output io_pkg::io_word_t rdata
);

    logic default_ack;

    // Unmapped port, one-shot ack and no data
    always_ff @(posedge clk) begin
        if (reset)
            default_ack <= 1'b0;
        else
            default_ack <= default_cs & ~default_ack;
    end

    assign ack = leds_ack | irq_ack | timer_ack | default_ack;

    // Idle blocks drive zero
    assign rdata.word = leds_rdata.word | irq_rdata.word | timer_rdata.word;

endmodule

`default_nettype wire

// File: io_subsystem.sv
// I/O port subsystem top
`timescale 1ns/1ps
`default_nettype none

module io_subsystem #(
    parameter int NUM_LEDS = 8,
    parameter int TIMER_PRESCALE = 4
) (
    input logic clk,
    input logic reset,
    input logic access,
    input logic [io_pkg::IO_ADDR_W:1] addr,
    input logic wr_en,
    input logic [1:0] bytesel,
    input logic [io_pkg::DATA_W-1:0] wdata,
    output logic [io_pkg::DATA_W-1:0] rdata,
    output logic ack,
    output logic [NUM_LEDS-1:0] leds,
    output logic [io_pkg::NUM_IRQS-1:0] irqs,
    output logic nmi
);
    import io_pkg::*;

    logic leds_cs;
    logic irq_cs;
    logic timer_cs;
    logic default_cs;
    logic leds_ack;
    logic irq_ack;
    logic timer_ack;
    logic timer_intr;
    io_word_t leds_rdata;
    io_word_t irq_rdata;
    io_word_t timer_rdata;
    io_word_t bus_rdata;

    io_req_if req_bus();

    io_decode io_decode_inst (
        .clk(clk),
        .reset(reset),
        .access(access),
        .addr(addr),
        .wr_en(wr_en),
        .bytesel(bytesel),
        .wdata(wdata),
        .ack(ack),
        .leds_cs(leds_cs),
        .irq_cs(irq_cs),
        .timer_cs(timer_cs),
        .default_cs(default_cs),
        .req(req_bus.decoder)
    );

    io_leds_register #(.NUM_LEDS(NUM_LEDS)) io_leds_register_inst (
        .clk(clk),
        .reset(reset),
        .cs(leds_cs),
        .req(req_bus.target),
        .ack(leds_ack),
        .rdata(leds_rdata),
        .leds(leds)
    );

    io_irq_control io_irq_control_inst (
        .clk(clk),
        .reset(reset),
        .cs(irq_cs),
        .timer_intr(timer_intr),
        .req(req_bus.target),
        .ack(irq_ack),
        .rdata(irq_rdata),
        .irqs(irqs),
        .nmi(nmi)
    );

    io_timer #(.TIMER_PRESCALE(TIMER_PRESCALE)) io_timer_inst (
        .clk(clk),
        .reset(reset),
        .cs(timer_cs),
        .req(req_bus.target),
        .ack(timer_ack),
        .rdata(timer_rdata),
        .intr(timer_intr)
    );

    io_response io_response_inst (
        .clk(clk),
        .reset(reset),
        .default_cs(default_cs),
        .leds_ack(leds_ack),
        .leds_rdata(leds_rdata),
        .irq_ack(irq_ack),
        .irq_rdata(irq_rdata),
        .timer_ack(timer_ack),
        .timer_rdata(timer_rdata),
        .ack(ack),
        .rdata(bus_rdata)
    );

    assign rdata = bus_rdata.word;

endmodule

`default_nettype wire

// File: io_subsystem_props.sv
// Bus handshake assertions
`timescale 1ns/1ps
`default_nettype none

module io_subsystem_props (
    input logic clk,
    input logic reset,
    input logic access,
    input logic ack,
    input logic [io_pkg::DATA_W-1:0] rdata
);

    // One pulse per request
    ack_single_cycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else $error("ack held high for two cycles");

    ack_one_clock_latency: assert property (
        @(posedge clk) disable iff (reset) $rose(access) |=> ack
    ) else $error("ack did not follow access after one clock");

    rdata_zero_when_idle: assert property (
        @(posedge clk) disable iff (reset) !ack |-> (rdata == '0)
    ) else $error("rdata not zero outside ack");

endmodule

bind io_subsystem io_subsystem_props io_subsystem_props_inst (
    .clk(clk),
    .reset(reset),
    .access(access),
    .ack(ack),
    .rdata(rdata)
);

`default_nettype wire

// File: io_subsystem_tb.sv
// I/O subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module io_subsystem_tb;
    import io_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_TESTS = 5;
    localparam int CLOCKS_PER_TEST = 200;
    localparam int ACK_TIMEOUT = 8; // Clocks to wait for ack
    localparam logic [15:0] UNMAPPED_PORT = 16'h1234;

    logic clk;
    logic reset;
    logic access;
    logic [IO_ADDR_W:1] addr;
    logic wr_en;
    logic [1:0] bytesel;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic ack;
    logic [7:0] leds;
    logic [NUM_IRQS-1:0] irqs;
    logic nmi;
    logic ack_seen;
    int last_latency;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) tb_clock_gen_inst (
        .clk(clk),
        .reset(reset)
    );

    io_subsystem #(.NUM_LEDS(8), .TIMER_PRESCALE(4)) io_subsystem_inst (
        .clk(clk),
        .reset(reset),
        .access(access),
        .addr(addr),
        .wr_en(wr_en),
        .bytesel(bytesel),
        .wdata(wdata),
        .rdata(rdata),
        .ack(ack),
        .leds(leds),
        .irqs(irqs),
        .nmi(nmi)
    );

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", test_name, expected, actual);
            abort_run();
        end
    endtask

    // One request, held until ack, sampled at the falling edge
    task automatic bus_cycle(input logic [15:0] port, input logic write, input logic [1:0] be,
                             input logic [15:0] data, output logic [15:0] rd);
        @(negedge clk);
        access = 1'b1;
        addr = port[15:1];
        wr_en = write;
        bytesel = be;
        wdata = data;
        last_latency = 0;
        do begin
            @(negedge clk);
            last_latency++;
            if (last_latency > ACK_TIMEOUT) begin
                $display("No ack from port %h within %0d clocks", port, ACK_TIMEOUT);
                abort_run();
            end
        end while (!ack);
        rd = rdata;
        access = 1'b0;
        wr_en = 1'b0;
        bytesel = 2'b00;
        wdata = '0;
    endtask

    task automatic write_port(input logic [15:0] port, input logic [1:0] be,
                              input logic [15:0] data);
        logic [15:0] unused_rd;
        bus_cycle(port, 1'b1, be, data, unused_rd);
    endtask

    task automatic read_port(input logic [15:0] port, output logic [15:0] data);
        bus_cycle(port, 1'b0, 2'b11, 16'h0000, data);
    endtask

    task automatic test_reset_state();
        logic [15:0] rd;
        check_value("reset_leds", 0, leds);
        check_value("reset_irqs", 0, irqs);
        check_value("reset_nmi", 0, nmi);
        read_port(TIMER_PORT + 16'h2, rd);
        check_value("reset_timer_count", 0, rd);
    endtask

    task automatic test_leds();
        logic [15:0] data;
        logic [15:0] rd;
        logic [7:0] expected;
        data = 16'($urandom);
        write_port(LEDS_PORT, 2'b11, data);
        check_value("leds_ack_latency", 1, last_latency);
        expected = data[7:0];
        read_port(LEDS_PORT, rd);
        check_value("leds_readback", {8'h00, expected}, rd);
        check_value("leds_read_latency", 1, last_latency);
        data = 16'($urandom);
        write_port(LEDS_PORT, 2'b10, data); // High byte, no LEDs there
        check_value("leds_high_byte", expected, leds);
        data = 16'($urandom);
        write_port(LEDS_PORT, 2'b01, data);
        expected = data[7:0];
        check_value("leds_low_byte", expected, leds);
    endtask

    task automatic test_irq_control();
        logic [15:0] data;
        logic [15:0] rd;
        data = 16'($urandom) & 16'h807f; // Test bits 6:0 and nmi
        write_port(IRQ_CONTROL_PORT, 2'b11, data);
        check_value("irq_lines", {1'b0, data[6:0]}, irqs);
        check_value("irq_nmi", data[15], nmi);
        read_port(IRQ_CONTROL_PORT, rd);
        check_value("irq_readback", data, rd);
        write_port(IRQ_CONTROL_PORT, 2'b11, 16'h0000);
        check_value("irq_cleared", 0, irqs);
    endtask

    task automatic test_timer();
        logic [15:0] rd;
        write_port(TIMER_PORT, 2'b11, 16'd5);
        read_port(TIMER_PORT, rd);
        check_value("timer_reload", 5, rd);
        write_port(TIMER_PORT + 16'h2, 2'b01, 16'h0001);
        while (!irqs[0])
            @(negedge clk);
        read_port(TIMER_PORT + 16'h2, rd);
        check_value("timer_count_in_range", 1, rd <= 16'd5);
        write_port(TIMER_PORT + 16'h2, 2'b01, 16'h0002); // Clear and stop
        check_value("timer_intr_cleared", 0, irqs[0]);
    endtask

    task automatic test_unmapped();
        logic [15:0] rd;
        logic [7:0] leds_before;
        read_port(UNMAPPED_PORT, rd);
        check_value("unmapped_read", 0, rd);
        check_value("unmapped_latency", 1, last_latency);
        leds_before = leds;
        write_port(UNMAPPED_PORT, 2'b11, 16'($urandom));
        check_value("unmapped_leds", leds_before, leds);
        check_value("unmapped_irqs", 0, {nmi, irqs});
        read_port(TIMER_PORT, rd);
        check_value("unmapped_timer_reload", 5, rd);
    endtask

    // Handshake rules checked on every falling edge
    always @(negedge clk) begin
        if (reset) begin
            ack_seen = 1'b0;
        end else begin
            if (!ack)
                check_value("rdata_idle", 0, rdata);
            if (ack_seen)
                check_value("ack_pulse", 0, ack);
            ack_seen = ack;
        end
    end

    initial begin
        #(NUM_TESTS * CLOCKS_PER_TEST * CLK_PERIOD);
        $display("Watchdog expired after %0d clocks", NUM_TESTS * CLOCKS_PER_TEST);
        abort_run();
    end

    initial begin
        access = 1'b0;
        addr = '0;
        wr_en = 1'b0;
        bytesel = 2'b00;
        wdata = '0;
        ack_seen = 1'b0;
        last_latency = 0;
        void'($urandom(32'hcfc7_214b));
        wait (!reset);
        @(negedge clk);
        test_reset_state();
        test_leds();
        test_irq_control();
        test_timer();
        test_unmapped();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: io_timer.sv
// Programmable interval timer
`timescale 1ns/1ps
`default_nettype none

module io_timer #(
    parameter int TIMER_PRESCALE = 4
) (
    input logic clk,
    input logic reset,
    input logic cs,
    io_req_if.target req,
    output logic ack,
    output io_pkg::io_word_t rdata,
    output logic intr
);
    import io_pkg::*;

    localparam int PRE_W = (TIMER_PRESCALE > 1) ? $clog2(TIMER_PRESCALE) : 1;

    io_word_t reload;
    io_word_t reload_nxt;
    logic [DATA_W-1:0] count;
    logic [PRE_W-1:0] pre_cnt;
    logic enabled;
    logic pending;
    logic access;
    logic tick;
    logic expire;

    assign access = cs & ~ack;
    assign tick = enabled && (pre_cnt == PRE_W'(TIMER_PRESCALE - 1));
    assign expire = tick && (count <= DATA_W'(1)); // Count reaches zero
    assign intr = pending;

    always_comb begin
        reload_nxt = reload;
        if (req.bytesel[0])
            reload_nxt.bytes.lo = req.wdata.bytes.lo;
        if (req.bytesel[1])
            reload_nxt.bytes.hi = req.wdata.bytes.hi;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
            rdata <= '0;
            reload <= '0;
            count <= '0;
            pre_cnt <= '0;
            enabled <= 1'b0;
            pending <= 1'b0;
        end else begin
            ack <= access;
            rdata <= '0;

            if (enabled)
                pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
            if (expire)
                count <= reload.word;
            else if (tick)
                count <= count - 1'b1;

            if (access && req.wr_en && !req.addr_sel) begin
                reload <= reload_nxt;
                count <= reload_nxt.word; // Restart from the new value
                pre_cnt <= '0;
            end
            if (access && req.wr_en && req.addr_sel && req.bytesel[0]) begin
                enabled <= req.wdata.bytes.lo[0];
                if (req.wdata.bytes.lo[1])
                    pending <= 1'b0;
            end
            if (expire)
                pending <= 1'b1; // New expiry beats a clear

            if (access && !req.wr_en)
                rdata.word <= req.addr_sel ? count : reload.word;
        end
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0; // Released away from the active edge
    end

endmodule

`default_nettype wire
